//--- verilog/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regAddr_t;

    localparam regAddr_t regZero = 5'd0;

    // major opcodes, only the kept ones
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_t;

    // funct field of SPECIAL
    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'b000000,
        FUNCT_SRL  = 6'b000010,
        FUNCT_SRA  = 6'b000011,
        FUNCT_SLLV = 6'b000100,
        FUNCT_SRLV = 6'b000110,
        FUNCT_SRAV = 6'b000111,
        FUNCT_ADD  = 6'b100000,
        FUNCT_ADDU = 6'b100001,
        FUNCT_SUB  = 6'b100010,
        FUNCT_SUBU = 6'b100011,
        FUNCT_AND  = 6'b100100,
        FUNCT_OR   = 6'b100101,
        FUNCT_XOR  = 6'b100110,
        FUNCT_NOR  = 6'b100111,
        FUNCT_SLT  = 6'b101010,
        FUNCT_SLTU = 6'b101011
    } funct_t;

    // variable shifts share SLL/SRL/SRA, amount comes in operand A
    typedef enum logic [3:0] {
        ALU_AND  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_NOR  = 4'd3,
        ALU_ADD  = 4'd4,
        ALU_ADDU = 4'd5,
        ALU_SUB  = 4'd6,
        ALU_SUBU = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13
    } aluOp_t;

endpackage

//--- verilog/stageIf.sv
// decode -> execute
interface decodeIf;
    import mipsPkg::*;

    logic     valid;
    aluOp_t   aluOp;
    word_t    operandA;
    word_t    operandB;
    regAddr_t regWaddr;
    logic     regWen;
    logic     undefined;

    modport src (output valid, aluOp, operandA, operandB,
                 output regWaddr, regWen, undefined);
    modport dst (input valid, aluOp, operandA, operandB,
                 input regWaddr, regWen, undefined);
endinterface

// execute -> writeback
interface execIf;
    import mipsPkg::*;

    logic     valid;
    word_t    result;
    logic     overflow;
    regAddr_t regWaddr;
    logic     regWen;
    logic     undefined;

    modport src (output valid, result, overflow, regWaddr, regWen, undefined);
    modport dst (input valid, result, overflow, regWaddr, regWen, undefined);
endinterface

//--- verilog/instrDecode.sv
module instrDecode (
    input  logic            clk,
    input  logic            rstN,
    input  logic            instrValid,
    input  mipsPkg::instr_t instr,
    input  mipsPkg::word_t  rsValue,
    input  mipsPkg::word_t  rtValue,
    decodeIf.src            dec
);
    import mipsPkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rt;
    regAddr_t rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    word_t    immExt;

    aluOp_t   aluOpNext;
    logic     undefNext;
    logic     shiftConst;
    logic     shiftVar;
    logic     useImm;
    word_t    operandANext;

    assign opcode = opcode_t'(instr[31:26]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = funct_t'(instr[5:0]);
    assign imm    = instr[15:0];

    // andi/ori/xori/lui have opcode bits 29:28 set -> zero extend
    assign immExt = (instr[29:28] == 2'b11) ? {16'd0, imm} : {{16{imm[15]}}, imm};
    assign useImm = (opcode != OP_SPECIAL);

    always_comb begin
        aluOpNext  = ALU_ADDU;
        undefNext  = 1'b0;
        shiftConst = 1'b0;
        shiftVar   = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FUNCT_AND:  aluOpNext = ALU_AND;
                    FUNCT_OR:   aluOpNext = ALU_OR;
                    FUNCT_XOR:  aluOpNext = ALU_XOR;
                    FUNCT_NOR:  aluOpNext = ALU_NOR;
                    FUNCT_ADD:  aluOpNext = ALU_ADD;
                    FUNCT_ADDU: aluOpNext = ALU_ADDU;
                    FUNCT_SUB:  aluOpNext = ALU_SUB;
                    FUNCT_SUBU: aluOpNext = ALU_SUBU;
                    FUNCT_SLT:  aluOpNext = ALU_SLT;
                    FUNCT_SLTU: aluOpNext = ALU_SLTU;
                    FUNCT_SLL: begin
                        aluOpNext  = ALU_SLL;
                        shiftConst = 1'b1;
                    end
                    FUNCT_SRL: begin
                        aluOpNext  = ALU_SRL;
                        shiftConst = 1'b1;
                        undefNext  = instr[21]; // rotr
                    end
                    FUNCT_SRA: begin
                        aluOpNext  = ALU_SRA;
                        shiftConst = 1'b1;
                    end
                    FUNCT_SLLV: begin
                        aluOpNext = ALU_SLL;
                        shiftVar  = 1'b1;
                    end
                    FUNCT_SRLV: begin
                        aluOpNext = ALU_SRL;
                        shiftVar  = 1'b1;
                        undefNext = instr[6]; // rotrv
                    end
                    FUNCT_SRAV: begin
                        aluOpNext = ALU_SRA;
                        shiftVar  = 1'b1;
                    end
                    default: undefNext = 1'b1;
                endcase
            end
            OP_ADDI:  aluOpNext = ALU_ADD;
            OP_ADDIU: aluOpNext = ALU_ADDU;
            OP_SLTI:  aluOpNext = ALU_SLT;
            OP_SLTIU: aluOpNext = ALU_SLTU;
            OP_ANDI:  aluOpNext = ALU_AND;
            OP_ORI:   aluOpNext = ALU_OR;
            OP_XORI:  aluOpNext = ALU_XOR;
            OP_LUI:   aluOpNext = ALU_LUI;
            default:  undefNext = 1'b1;
        endcase
    end

    always_comb begin
        if (shiftConst)
            operandANext = {27'd0, shamt};
        else if (shiftVar)
            operandANext = {27'd0, rsValue[4:0]};
        else
            operandANext = rsValue;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dec.valid     <= 1'b0;
            dec.regWen    <= 1'b0;
            dec.undefined <= 1'b0;
        end else begin
            dec.valid     <= instrValid;
            dec.regWen    <= instrValid & ~undefNext; // every kept op writes
            dec.undefined <= instrValid & undefNext;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            dec.aluOp    <= aluOpNext;
            dec.operandA <= operandANext;
            dec.operandB <= useImm ? immExt : rtValue;
            dec.regWaddr <= useImm ? rt : rd;
        end
    end

endmodule

//--- verilog/aluExecute.sv
module aluExecute (
    input  logic clk,
    input  logic rstN,
    decodeIf.dst dec,
    execIf.src   exe
);
    import mipsPkg::*;

    word_t      a;
    word_t      b;
    logic [4:0] shAmt;
    word_t      sum;
    word_t      diff;
    logic       addOvf;
    logic       subOvf;
    logic       ovfNext;
    word_t      resultNext;

    assign a     = dec.operandA;
    assign b     = dec.operandB;
    assign shAmt = a[4:0];
    assign sum   = a + b;
    assign diff  = a - b;

    // signed overflow, operand signs vs result sign
    assign addOvf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign subOvf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (dec.aluOp)
            ALU_AND:  resultNext = a & b;
            ALU_OR:   resultNext = a | b;
            ALU_XOR:  resultNext = a ^ b;
            ALU_NOR:  resultNext = ~(a | b);
            ALU_ADD,
            ALU_ADDU: resultNext = sum;
            ALU_SUB,
            ALU_SUBU: resultNext = diff;
            ALU_SLT:  resultNext = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: resultNext = {31'd0, a < b};
            ALU_SLL:  resultNext = b << shAmt;
            ALU_SRL:  resultNext = b >> shAmt;
            ALU_SRA:  resultNext = $signed(b) >>> shAmt; // sign fill
            ALU_LUI:  resultNext = {b[15:0], 16'd0};
            default:  resultNext = '0;
        endcase
    end

    // addu/subu never trap
    assign ovfNext = (dec.aluOp == ALU_ADD && addOvf) || (dec.aluOp == ALU_SUB && subOvf);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exe.valid     <= 1'b0;
            exe.overflow  <= 1'b0;
            exe.regWen    <= 1'b0;
            exe.undefined <= 1'b0;
        end else begin
            exe.valid     <= dec.valid;
            exe.overflow  <= dec.valid & ovfNext;
            exe.regWen    <= dec.valid & dec.regWen;
            exe.undefined <= dec.valid & dec.undefined;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            exe.result   <= resultNext;
            exe.regWaddr <= dec.regWaddr;
        end
    end

endmodule

//--- verilog/writebackResult.sv
module writebackResult (
    input  logic               clk,
    input  logic               rstN,
    execIf.dst                 exe,
    output logic               wbValid,
    output logic               wbWen,
    output mipsPkg::regAddr_t  wbAddr,
    output mipsPkg::word_t     wbData,
    output logic               excOverflow,
    output logic               excUndefined
);
    import mipsPkg::*;

    logic wenNext;

    // no write on a trap or to r0
    assign wenNext = exe.valid & exe.regWen & ~exe.overflow & ~exe.undefined
                   & (exe.regWaddr != regZero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid      <= 1'b0;
            wbWen        <= 1'b0;
            excOverflow  <= 1'b0;
            excUndefined <= 1'b0;
        end else begin
            wbValid      <= exe.valid;
            wbWen        <= wenNext;
            excOverflow  <= exe.valid & exe.overflow;   // one pulse per instr
            excUndefined <= exe.valid & exe.undefined;
        end
    end

    always_ff @(posedge clk) begin
        if (exe.valid) begin
            wbAddr <= exe.regWaddr;
            wbData <= exe.result;
        end
    end

endmodule

//--- verilog/intCore.sv
module intCore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instrValid,
    input  mipsPkg::instr_t   instr,
    input  mipsPkg::word_t    rsValue,
    input  mipsPkg::word_t    rtValue,
    output logic              wbValid,
    output logic              wbWen,
    output mipsPkg::regAddr_t wbAddr,
    output mipsPkg::word_t    wbData,
    output logic              excOverflow,
    output logic              excUndefined
);

    decodeIf decBus ();
    execIf   exeBus ();

    // decode, operands captured with the instruction
    instrDecode uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rsValue    (rsValue),
        .rtValue    (rtValue),
        .dec        (decBus.src)
    );

    aluExecute uExecute (
        .clk  (clk),
        .rstN (rstN),
        .dec  (decBus.dst),
        .exe  (exeBus.src)
    );

    writebackResult uWriteback (
        .clk          (clk),
        .rstN         (rstN),
        .exe          (exeBus.dst),
        .wbValid      (wbValid),
        .wbWen        (wbWen),
        .wbAddr       (wbAddr),
        .wbData       (wbData),
        .excOverflow  (excOverflow),
        .excUndefined (excUndefined)
    );

endmodule

//--- bench/intCore_properties.sv
module intCore_properties (
    input logic clk,
    input logic rstN,
    input logic instrValid,
    input logic wbValid,
    input logic wbWen,
    input logic excOverflow,
    input logic excUndefined
);
    timeunit 1ns;
    timeprecision 1ps;

    // three register stages from the sampling edge to wbValid
    validLatency: assert property (@(posedge clk) disable iff (!rstN)
        wbValid == $past(instrValid, 3))
        else $error("wbValid does not follow instrValid by 3 cycles");

    // result qualifiers only with a valid result
    qualifiedByValid: assert property (@(posedge clk)
        (wbWen || excOverflow || excUndefined) |-> wbValid)
        else $error("write enable or exception without wbValid");

    noWriteOnException: assert property (@(posedge clk)
        (excOverflow || excUndefined) |-> !wbWen)
        else $error("register write together with an exception");

endmodule

//--- bench/intCoreTb.sv
module intCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    typedef struct packed {
        instr_t   instr;
        word_t    rs;
        word_t    rt;
        logic     wen;
        regAddr_t addr;
        word_t    data;
        logic     ovf;
        logic     undef;
    } row_t;

    localparam int randomCount = 40;

    logic     clk = 1'b0;
    logic     rstN;
    logic     instrValid;
    instr_t   instr;
    word_t    rsValue;
    word_t    rtValue;
    logic     wbValid;
    logic     wbWen;
    regAddr_t wbAddr;
    word_t    wbData;
    logic     excOverflow;
    logic     excUndefined;

    row_t stimRows[$];
    row_t expQ[$];
    int   dueQ[$];
    int   tableLen = 0;
    int   numRows = 0;
    int   checkedCount = 0;
    int   valueErrors = 0;
    int   otherErrors = 0;
    int   cycle = 0;
    logic [15:0] lfsr = 16'd74;

    funct_t keptFunct[16] = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_SLLV, FUNCT_SRLV,
        FUNCT_SRAV, FUNCT_ADD, FUNCT_ADDU, FUNCT_SUB, FUNCT_SUBU, FUNCT_AND, FUNCT_OR,
        FUNCT_XOR, FUNCT_NOR, FUNCT_SLT, FUNCT_SLTU};

    intCore uut (.*);

    bind intCore intCore_properties props (
        .clk          (clk),
        .rstN         (rstN),
        .instrValid   (instrValid),
        .wbValid      (wbValid),
        .wbWen        (wbWen),
        .excOverflow  (excOverflow),
        .excUndefined (excUndefined)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic instr_t encodeR(funct_t fn, int rs, int rt, int rd, int sh);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic instr_t encodeI(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic instr_t randomInstr();
        logic [2:0]  kind;
        logic [25:0] body;
        logic [5:0]  fn;
        kind = 3'(takeBits(3));
        body = 26'(takeBits(26));
        if (kind < 3'd4) begin
            fn = (kind == 3'd3) ? 6'(takeBits(6)) : keptFunct[4'(takeBits(4))]; // some raw
            return {6'd0, body[25:6], fn};
        end
        if (kind == 3'd7)
            return {6'(takeBits(6)), body};
        return {3'b001, 3'(takeBits(3)), body}; // immediate group
    endfunction

    function automatic row_t referenceRow(instr_t i, word_t rs, word_t rt);
        row_t        r;
        word_t       zImm;
        word_t       sImm;
        logic [32:0] wide;
        r.instr = i;
        r.rs    = rs;
        r.rt    = rt;
        r.ovf   = 1'b0;
        r.undef = 1'b0;
        r.data  = '0;
        zImm = {16'd0, i[15:0]};
        sImm = {{16{i[15]}}, i[15:0]};
        if (i[31:26] == OP_SPECIAL) begin
            r.addr = i[15:11];
            case (i[5:0])
                FUNCT_AND:  r.data = rs & rt;
                FUNCT_OR:   r.data = rs | rt;
                FUNCT_XOR:  r.data = rs ^ rt;
                FUNCT_NOR:  r.data = ~(rs | rt);
                FUNCT_ADD, FUNCT_ADDU: r.data = rs + rt;
                FUNCT_SUB, FUNCT_SUBU: r.data = rs - rt;
                FUNCT_SLT:  r.data = {31'd0, $signed(rs) < $signed(rt)};
                FUNCT_SLTU: r.data = {31'd0, rs < rt};
                FUNCT_SLL:  r.data = rt << i[10:6];
                FUNCT_SRL:  r.data = rt >> i[10:6];
                FUNCT_SRA:  r.data = $signed(rt) >>> i[10:6];
                FUNCT_SLLV: r.data = rt << rs[4:0];
                FUNCT_SRLV: r.data = rt >> rs[4:0];
                FUNCT_SRAV: r.data = $signed(rt) >>> rs[4:0];
                default:    r.undef = 1'b1;
            endcase
            // rotate forms hide behind srl and srlv
            if ((i[5:0] == FUNCT_SRL && i[21]) || (i[5:0] == FUNCT_SRLV && i[6]))
                r.undef = 1'b1;
            wide = (i[5:0] == FUNCT_SUB) ? {rs[31], rs} - {rt[31], rt}
                                         : {rs[31], rs} + {rt[31], rt};
            r.ovf = (i[5:0] == FUNCT_ADD || i[5:0] == FUNCT_SUB) && (wide[32] != wide[31]);
        end else begin
            r.addr = i[20:16];
            case (i[31:26])
                OP_ADDI, OP_ADDIU: r.data = rs + sImm;
                OP_SLTI:  r.data = {31'd0, $signed(rs) < $signed(sImm)};
                OP_SLTIU: r.data = {31'd0, rs < sImm};
                OP_ANDI:  r.data = rs & zImm;
                OP_ORI:   r.data = rs | zImm;
                OP_XORI:  r.data = rs ^ zImm;
                OP_LUI:   r.data = {i[15:0], 16'd0};
                default:  r.undef = 1'b1;
            endcase
            wide = {rs[31], rs} + {sImm[31], sImm};
            r.ovf = (i[31:26] == OP_ADDI) && (wide[32] != wide[31]);
        end
        r.wen = !r.undef && !r.ovf && (r.addr != regZero);
        return r;
    endfunction

    task automatic addRow(instr_t i, word_t rs, word_t rt, int wen, int addr, word_t data,
                          int ovf, int undef);
        row_t r;
        r.instr = i;
        r.rs    = rs;
        r.rt    = rt;
        r.wen   = (wen != 0);
        r.addr  = regAddr_t'(addr);
        r.data  = data;
        r.ovf   = (ovf != 0);
        r.undef = (undef != 0);
        stimRows.push_back(r);
    endtask

    task automatic buildRows();
        instr_t i;
        word_t  rs;
        word_t  rt;
        addRow(encodeR(FUNCT_AND, 1, 2, 3, 0), 'hF0F000FF, 'h0FF00F0F, 1, 3, 'h00F0000F, 0, 0);
        addRow(encodeR(FUNCT_OR, 1, 2, 3, 0), 'hF0F000FF, 'h0FF00F0F, 1, 3, 'hFFF00FFF, 0, 0);
        addRow(encodeR(FUNCT_XOR, 1, 2, 3, 0), 'hF0F000FF, 'h0FF00F0F, 1, 3, 'hFF000FF0, 0, 0);
        addRow(encodeR(FUNCT_NOR, 1, 2, 3, 0), 'hF0F000FF, 'h0FF00F0F, 1, 3, 'h000FF000, 0, 0);
        addRow(encodeR(FUNCT_ADD, 1, 2, 4, 0), 'h00000007, 'h00000005, 1, 4, 'h0000000C, 0, 0);
        addRow(encodeR(FUNCT_ADDU, 1, 2, 5, 0), 'hFFFFFFFF, 'h00000001, 1, 5, 'h00000000, 0, 0);
        addRow(encodeR(FUNCT_SUB, 1, 2, 6, 0), 'h00000005, 'h00000007, 1, 6, 'hFFFFFFFE, 0, 0);
        addRow(encodeR(FUNCT_SUBU, 1, 2, 7, 0), 'h00000000, 'h00000001, 1, 7, 'hFFFFFFFF, 0, 0);
        addRow(encodeR(FUNCT_SLT, 1, 2, 8, 0), 'hFFFFFFFF, 'h00000001, 1, 8, 'h00000001, 0, 0);
        addRow(encodeR(FUNCT_SLTU, 1, 2, 9, 0), 'hFFFFFFFF, 'h00000001, 1, 9, 'h00000000, 0, 0);
        addRow(encodeR(FUNCT_SLL, 0, 2, 10, 4), 'hDEADBEEF, 'h00000003, 1, 10, 'h00000030, 0, 0);
        addRow(encodeR(FUNCT_SRL, 0, 2, 11, 31), 'h00000000, 'h80000000, 1, 11, 'h00000001, 0, 0);
        addRow(encodeR(FUNCT_SRA, 0, 2, 12, 4), 'h00000000, 'h80000000, 1, 12, 'hF8000000, 0, 0);
        addRow(encodeR(FUNCT_SLLV, 1, 2, 13, 0), 'h00000024, 'h00000001, 1, 13, 'h00000010, 0, 0);
        addRow(encodeR(FUNCT_SRLV, 1, 2, 14, 0), 'hFFFFFFE8, 'h80000000, 1, 14, 'h00800000, 0, 0);
        addRow(encodeR(FUNCT_SRAV, 1, 2, 15, 0), 'h00000021, 'h80000000, 1, 15, 'hC0000000, 0, 0);
        addRow(encodeI(OP_ADDI, 1, 16, 'hFFFF), 'h00000010, 0, 1, 16, 'h0000000F, 0, 0);
        addRow(encodeI(OP_ADDIU, 1, 17, 'h8000), 'h00000000, 0, 1, 17, 'hFFFF8000, 0, 0);
        addRow(encodeI(OP_SLTI, 1, 18, 'hFFFF), 'hFFFFFFFE, 0, 1, 18, 'h00000001, 0, 0);
        addRow(encodeI(OP_SLTIU, 1, 19, 'hFFFF), 'h00000005, 0, 1, 19, 'h00000001, 0, 0);
        addRow(encodeI(OP_ANDI, 1, 20, 'h8001), 'hFFFFFFFF, 0, 1, 20, 'h00008001, 0, 0);
        addRow(encodeI(OP_ORI, 1, 21, 'h8000), 'h12340000, 0, 1, 21, 'h12348000, 0, 0);
        addRow(encodeI(OP_XORI, 1, 22, 'hFFFF), 'hFFFF0000, 0, 1, 22, 'hFFFFFFFF, 0, 0);
        addRow(encodeI(OP_LUI, 0, 23, 'hABCD), 'h00000000, 0, 1, 23, 'hABCD0000, 0, 0);
        addRow(encodeR(FUNCT_ADD, 1, 2, 24, 0), 'h7FFFFFFF, 'h00000001, 0, 24, 'h80000000, 1, 0);
        addRow(encodeR(FUNCT_SUB, 1, 2, 25, 0), 'h80000000, 'h00000001, 0, 25, 'h7FFFFFFF, 1, 0);
        addRow(encodeI(OP_ADDI, 1, 26, 'h0001), 'h7FFFFFFF, 0, 0, 26, 'h80000000, 1, 0);
        addRow(encodeR(FUNCT_ADDU, 1, 2, 27, 0), 'h7FFFFFFF, 'h00000001, 1, 27, 'h80000000, 0, 0);
        addRow(encodeR(FUNCT_SUBU, 1, 2, 28, 0), 'h80000000, 'h00000001, 1, 28, 'h7FFFFFFF, 0, 0);
        addRow('h8C220000, 0, 0, 0, 0, 0, 0, 1); // lw
        addRow('h00220018, 0, 0, 0, 0, 0, 0, 1); // mult
        addRow(encodeR(FUNCT_SRL, 1, 2, 29, 8), 0, 0, 0, 29, 0, 0, 1); // rotr
        addRow(encodeR(FUNCT_ADDU, 1, 2, 0, 0), 'h00000003, 'h00000004, 0, 0, 'h00000007, 0, 0);
        tableLen = stimRows.size();
        for (int n = 0; n < randomCount; n++) begin
            i  = randomInstr();
            rs = takeBits(32);
            rt = takeBits(32);
            stimRows.push_back(referenceRow(i, rs, rt));
        end
        numRows = stimRows.size();
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkAddr(string name, regAddr_t got, regAddr_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic compareRow(row_t e, int due);
        if (cycle != due) begin
            $display("result of instruction %h arrived in cycle %0d, expected in cycle %0d",
                     e.instr, cycle, due);
            otherErrors++;
        end
        checkFlag("excUndefined", excUndefined, e.undef);
        checkFlag("excOverflow", excOverflow, e.ovf);
        checkFlag("wbWen", wbWen, e.wen);
        if (!e.undef) begin // data of an undefined op is don't care
            checkAddr("wbAddr", wbAddr, e.addr);
            checkWord("wbData", wbData, e.data);
        end
        checkedCount++;
    endtask

    // sample half a cycle away from the driving edge
    always @(negedge clk) begin
        if (!rstN) begin
            if (wbValid || wbWen || excOverflow || excUndefined) begin
                $display("outputs were active while reset was asserted");
                otherErrors++;
            end
        end else if (wbValid) begin
            if (expQ.size() == 0) begin
                $display("wbValid was high with no instruction in flight");
                otherErrors++;
            end else begin
                compareRow(expQ.pop_front(), dueQ.pop_front());
            end
        end
    end

    initial begin
        wait (tableLen > 0);
        #((tableLen + randomCount + 20) * 8);
        $display("watchdog expired, DUT outputs stopped arriving after %0d of %0d results",
                 checkedCount, numRows);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rsValue    = '0;
        rtValue    = '0;
        buildRows();
        repeat (8) @(posedge clk);
        #1;
        rstN = 1'b1;
        foreach (stimRows[n]) begin
            @(posedge clk);
            #1;
            instrValid = 1'b1;
            instr      = stimRows[n].instr;
            rsValue    = stimRows[n].rs;
            rtValue    = stimRows[n].rt;
            expQ.push_back(stimRows[n]);
            dueQ.push_back(cycle + 3); // three register stages
        end
        @(posedge clk);
        #1;
        instrValid = 1'b0;
        wait (checkedCount == numRows);
        $display("checked %0d of %0d results, %0d value errors, %0d other errors",
                 checkedCount, numRows, valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/mipsPkg.sv
verilog/stageIf.sv
verilog/instrDecode.sv
verilog/aluExecute.sv
verilog/writebackResult.sv
verilog/intCore.sv
bench/intCore_properties.sv
bench/intCoreTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := intCoreTb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

# the log decides, a run without any verdict counts as a failure
test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "no verdict in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
